//--- source/videoPkg.sv
// 640x480 timing at one pixel per clock; register map is byte addressed, word aligned only
`default_nettype none

package videoPkg;

    // ------------------------------
    // widths with a meaning
    // ------------------------------
    typedef logic [9:0]  coord_t;
    typedef logic [23:0] rgb_t;
    // 0 is transparent
    typedef logic [3:0]  palIdx_t;
    typedef logic [7:0]  apbAddr_t;
    typedef logic [31:0] apbData_t;
    // eight 4-bit pixels, column 0 in the top nibble
    typedef logic [31:0] patternRow_t;
    typedef logic [3:0]  rowAddr_t;

    // ------------------------------
    // display timing
    // ------------------------------
    localparam coord_t hActive = 10'd640;
    localparam coord_t hFront  = 10'd16;
    localparam coord_t hSync   = 10'd96;
    localparam coord_t hBack   = 10'd48;
    localparam coord_t hTotal  = hActive + hFront + hSync + hBack;
    localparam coord_t vActive = 10'd480;
    localparam coord_t vFront  = 10'd10;
    localparam coord_t vSync   = 10'd2;
    localparam coord_t vBack   = 10'd33;
    localparam coord_t vTotal  = vActive + vFront + vSync + vBack;

    // sprite geometry
    localparam int spriteSize  = 8;
    localparam int spriteRows  = 16;
    localparam int paletteSize = 16;

    // ------------------------------
    // register map
    // ------------------------------
    localparam apbAddr_t regSprite0Pos = 8'h00;
    localparam apbAddr_t regSprite1Pos = 8'h04;
    localparam apbAddr_t regBackground = 8'h08;
    // each palette window spans 64 bytes
    localparam apbAddr_t palette0Base  = 8'h40;
    localparam apbAddr_t palette1Base  = 8'h80;

    // ------------------------------
    // bundles
    // ------------------------------
    typedef struct packed {
        logic     psel;
        logic     penable;
        logic     pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    typedef struct packed {
        apbData_t prdata;
        logic     pready;
        logic     pslverr;
    } apbRsp_t;

    typedef struct packed {
        coord_t y;
        coord_t x;
    } spriteOrigin_t;

    // timing state of one pixel
    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
        logic   hSyncN;
        logic   vSyncN;
    } pixelPos_t;

    // one sprite's answer for one pixel
    typedef struct packed {
        logic    hit;
        palIdx_t index;
    } spriteTap_t;

    typedef struct packed {
        logic    valid;
        // 0 selects sprite 0 palette
        logic    palSel;
        palIdx_t entry;
        rgb_t    color;
    } paletteWrite_t;

    typedef struct packed {
        rgb_t   rgb;
        coord_t x;
        coord_t y;
        logic   active;
        logic   hSyncN;
        logic   vSyncN;
    } videoOut_t;

endpackage

`default_nettype wire

//--- source/vgaTimer.sv
// free running, one pixel per clock; first pixel after reset is reported inactive
`default_nettype none

module vgaTimer (
    input  wire                 Clk,
    input  wire                 arstN,
    output videoPkg::pixelPos_t pos
);
    import videoPkg::*;

    coord_t nextX;
    coord_t nextY;
    logic   nextActive;
    logic   nextHSyncN;
    logic   nextVSyncN;

    // ------------------------------
    // next count
    // ------------------------------
    always_comb
    begin
        nextX = pos.x + 10'd1;
        nextY = pos.y;
        // end of line, step to next row
        if (pos.x == hTotal - 10'd1)
        begin
            nextX = '0;
            if (pos.y == vTotal - 10'd1)
            begin
                nextY = '0;
            end
            else
            begin
                nextY = pos.y + 10'd1;
            end
        end
    end

    // flags decoded ahead so they line up with the registered count
    assign nextActive = (nextX < hActive) && (nextY < vActive);
    // hsync low from 656 through 751
    assign nextHSyncN = !((nextX >= hActive + hFront) &&
                          (nextX <  hActive + hFront + hSync));
    // vsync low on lines 490 and 491
    assign nextVSyncN = !((nextY >= vActive + vFront) &&
                          (nextY <  vActive + vFront + vSync));

    // ------------------------------
    // count register
    // ------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            pos.x      <= '0;
            pos.y      <= '0;
            pos.active <= 1'b0;
            // sync idles high
            pos.hSyncN <= 1'b1;
            pos.vSyncN <= 1'b1;
        end
        else
        begin
            pos.x      <= nextX;
            pos.y      <= nextY;
            pos.active <= nextActive;
            pos.hSyncN <= nextHSyncN;
            pos.vSyncN <= nextVSyncN;
        end
    end

    // counter never leaves the line
    xInRange: assert property (@(posedge Clk) disable iff (!arstN)
        pos.x < hTotal);

endmodule

`default_nettype wire

//--- source/apbRegs.sv
// APB slave with no wait states; palette entries are write-only and read back as zero
`default_nettype none

module apbRegs (
    input  wire                     Clk,
    input  wire                     arstN,
    input  wire videoPkg::apbReq_t  req,
    output videoPkg::apbRsp_t       rsp,
    output videoPkg::spriteOrigin_t sprite0Pos,
    output videoPkg::spriteOrigin_t sprite1Pos,
    output videoPkg::rgb_t          background,
    output videoPkg::paletteWrite_t palWrite
);
    import videoPkg::*;

    logic     access;
    logic     aligned;
    logic     hitPos0;
    logic     hitPos1;
    logic     hitBg;
    logic     hitPal0;
    logic     hitPal1;
    logic     addrOk;
    logic     wrOk;
    apbData_t readData;

    // ------------------------------
    // address decode
    // ------------------------------
    assign access  = req.psel && req.penable;
    assign aligned = (req.paddr[1:0] == 2'b00);
    assign hitPos0 = (req.paddr == regSprite0Pos);
    assign hitPos1 = (req.paddr == regSprite1Pos);
    assign hitBg   = (req.paddr == regBackground);
    // palette windows by top two address bits
    assign hitPal0 = (req.paddr[7:6] == palette0Base[7:6]);
    assign hitPal1 = (req.paddr[7:6] == palette1Base[7:6]);
    assign addrOk  = aligned && (hitPos0 || hitPos1 || hitBg || hitPal0 || hitPal1);
    // erroring writes are dropped here
    assign wrOk    = access && req.pwrite && addrOk;

    // read mux, palettes give zero
    always_comb
    begin
        readData = '0;
        if (access && !req.pwrite && addrOk)
        begin
            if (hitPos0)
            begin
                readData = {6'b0, sprite0Pos.y, 6'b0, sprite0Pos.x};
            end
            else if (hitPos1)
            begin
                readData = {6'b0, sprite1Pos.y, 6'b0, sprite1Pos.x};
            end
            else if (hitBg)
            begin
                readData = {8'b0, background};
            end
        end
    end

    // always ready, error only in the access cycle
    assign rsp.prdata  = readData;
    assign rsp.pready  = 1'b1;
    assign rsp.pslverr = access && !addrOk;

    // ------------------------------
    // control registers
    // ------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            sprite0Pos <= '0;
            sprite1Pos <= '0;
            background <= '0;
        end
        else if (wrOk)
        begin
            // x in 9..0, y in 25..16
            if (hitPos0)
            begin
                sprite0Pos.x <= req.pwdata[9:0];
                sprite0Pos.y <= req.pwdata[25:16];
            end
            if (hitPos1)
            begin
                sprite1Pos.x <= req.pwdata[9:0];
                sprite1Pos.y <= req.pwdata[25:16];
            end
            if (hitBg)
            begin
                background <= req.pwdata[23:0];
            end
        end
    end

    // palette write lasts the access cycle only
    assign palWrite.valid  = wrOk && (hitPal0 || hitPal1);
    assign palWrite.palSel = hitPal1;
    assign palWrite.entry  = req.paddr[5:2];
    assign palWrite.color  = req.pwdata[23:0];

    // handshake rules
    penableNeedsPsel: assert property (@(posedge Clk) disable iff (!arstN)
        req.penable |-> req.psel);
    setupThenAccess: assert property (@(posedge Clk) disable iff (!arstN)
        (req.psel && !req.penable) |=> (req.psel && req.penable));

endmodule

`default_nettype wire

//--- source/spriteFetch.sv
// 8x8 sprite, pattern ROM loaded from spriteData.hex in the working directory
`default_nettype none

module spriteFetch #(
    parameter int romBase = 0
) (
    input  wire                          Clk,
    input  wire                          arstN,
    input  wire videoPkg::pixelPos_t     pos,
    input  wire videoPkg::spriteOrigin_t origin,
    output videoPkg::spriteTap_t         tap,
    output videoPkg::pixelPos_t          posOut
);
    import videoPkg::*;

    // both sprites share one file, this unit reads its own rows
    patternRow_t patternRom [spriteRows];
    coord_t      dx;
    coord_t      dy;
    logic        inX;
    logic        inY;
    logic        hit;
    rowAddr_t    rowAddr;
    patternRow_t rowWord;
    logic [4:0]  nibLsb;
    palIdx_t     index;

    initial
    begin
        $readmemh("spriteData.hex", patternRom);
    end

    // ------------------------------
    // hit test
    // ------------------------------
    assign dx  = pos.x - origin.x;
    assign dy  = pos.y - origin.y;
    // lower bound first so dx cannot wrap
    assign inX = (pos.x >= origin.x) && (dx < coord_t'(spriteSize));
    assign inY = (pos.y >= origin.y) && (dy < coord_t'(spriteSize));
    assign hit = pos.active && inX && inY;

    // ------------------------------
    // pattern lookup
    // ------------------------------
    assign rowAddr = rowAddr_t'(romBase) + {1'b0, dy[2:0]};
    assign rowWord = patternRom[rowAddr];
    // column 0 sits in bits 31..28
    assign nibLsb  = {~dx[2:0], 2'b00};
    assign index   = rowWord[nibLsb +: 4];

    // tap and position move together
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            tap           <= '0;
            posOut.x      <= '0;
            posOut.y      <= '0;
            posOut.active <= 1'b0;
            posOut.hSyncN <= 1'b1;
            posOut.vSyncN <= 1'b1;
        end
        else
        begin
            tap.hit   <= hit;
            // no hit, no index
            tap.index <= hit ? index : '0;
            posOut    <= pos;
        end
    end

endmodule

`default_nettype wire

//--- source/colorMapper.sv
// two write-only 16-entry palettes, cleared by reset; index 0 is transparent
`default_nettype none

module colorMapper (
    input  wire                          Clk,
    input  wire                          arstN,
    input  wire videoPkg::spriteTap_t    tap0,
    input  wire videoPkg::spriteTap_t    tap1,
    input  wire videoPkg::pixelPos_t     pos,
    input  wire videoPkg::rgb_t          background,
    input  wire videoPkg::paletteWrite_t palWrite,
    output videoPkg::videoOut_t          video
);
    import videoPkg::*;

    rgb_t palette0 [paletteSize];
    rgb_t palette1 [paletteSize];
    rgb_t color;

    // ------------------------------
    // palette storage
    // ------------------------------
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < paletteSize; i++)
            begin
                palette0[i] <= '0;
                palette1[i] <= '0;
            end
        end
        else if (palWrite.valid)
        begin
            if (palWrite.palSel)
            begin
                palette1[palWrite.entry] <= palWrite.color;
            end
            else
            begin
                palette0[palWrite.entry] <= palWrite.color;
            end
        end
    end

    // ------------------------------
    // layer priority
    // ------------------------------
    always_comb
    begin
        // blanking is black
        if (!pos.active)
        begin
            color = '0;
        end
        // sprite 1 on top
        else if (tap1.hit && (tap1.index != '0))
        begin
            color = palette1[tap1.index];
        end
        else if (tap0.hit && (tap0.index != '0))
        begin
            color = palette0[tap0.index];
        end
        else
        begin
            color = background;
        end
    end

    // output stage, color and timing registered together
    always_ff @(posedge Clk or negedge arstN)
    begin
        if (!arstN)
        begin
            video.rgb    <= '0;
            video.x      <= '0;
            video.y      <= '0;
            video.active <= 1'b0;
            video.hSyncN <= 1'b1;
            video.vSyncN <= 1'b1;
        end
        else
        begin
            video.rgb    <= color;
            video.x      <= pos.x;
            video.y      <= pos.y;
            video.active <= pos.active;
            video.hSyncN <= pos.hSyncN;
            video.vSyncN <= pos.vSyncN;
        end
    end

    // register block sends single-cycle palette writes
    palWritePulse: assert property (@(posedge Clk) disable iff (!arstN)
        palWrite.valid |=> !palWrite.valid);

endmodule

`default_nettype wire

//--- source/videoTop.sv
// pixel output trails the timer count by two clocks; no pixel side back-pressure
`default_nettype none

module videoTop (
    input  wire                    Clk,
    input  wire                    arstN,
    input  wire videoPkg::apbReq_t apbReq,
    output videoPkg::apbRsp_t      apbRsp,
    output videoPkg::videoOut_t    video
);
    import videoPkg::*;

    pixelPos_t     timerPos;
    // position delayed alongside the taps
    pixelPos_t     fetchPos;
    spriteOrigin_t sprite0Pos;
    spriteOrigin_t sprite1Pos;
    rgb_t          background;
    paletteWrite_t palWrite;
    spriteTap_t    tap0;
    spriteTap_t    tap1;

    // ------------------------------
    // timing and control
    // ------------------------------
    vgaTimer i_timer (
        .Clk   (Clk),
        .arstN (arstN),
        .pos   (timerPos)
    );

    apbRegs i_regs (
        .Clk        (Clk),
        .arstN      (arstN),
        .req        (apbReq),
        .rsp        (apbRsp),
        .sprite0Pos (sprite0Pos),
        .sprite1Pos (sprite1Pos),
        .background (background),
        .palWrite   (palWrite)
    );

    // ------------------------------
    // sprite layers
    // ------------------------------
    spriteFetch #(.romBase(0)) i_sprite0 (
        .Clk    (Clk),
        .arstN  (arstN),
        .pos    (timerPos),
        .origin (sprite0Pos),
        .tap    (tap0),
        .posOut (fetchPos)
    );

    // its delayed position matches sprite 0's, left open
    spriteFetch #(.romBase(8)) i_sprite1 (
        .Clk    (Clk),
        .arstN  (arstN),
        .pos    (timerPos),
        .origin (sprite1Pos),
        .tap    (tap1),
        .posOut ()
    );

    colorMapper i_mapper (
        .Clk        (Clk),
        .arstN      (arstN),
        .tap0       (tap0),
        .tap1       (tap1),
        .pos        (fetchPos),
        .background (background),
        .palWrite   (palWrite),
        .video      (video)
    );

endmodule

`default_nettype wire

//--- verification/tbTests.svh
// directed tests for tbTop; pixels are sampled at the falling edge, coordinates come from video

// ------------------------------
// reference model
// ------------------------------
// column 0 sits in the top nibble of a row word
function automatic palIdx_t modelIndex(input int sprite, input int col, input int row);
    patternRow_t word;
    word = patternModel[sprite * spriteSize + row];
    return word[(spriteSize - 1 - col) * 4 +: 4];
endfunction

function automatic logic insideSprite(input int x, input int y, input int ox, input int oy);
    return (x >= ox) && (x < ox + spriteSize) && (y >= oy) && (y < oy + spriteSize);
endfunction

// sprite 1 over sprite 0 over background, black in blanking
function automatic rgb_t expectedColor(input int x, input int y);
    palIdx_t idx0;
    palIdx_t idx1;
    rgb_t    color;
    idx0 = '0;
    idx1 = '0;
    if (insideSprite(x, y, origin0X, origin0Y))
    begin
        idx0 = modelIndex(0, x - origin0X, y - origin0Y);
    end
    if (insideSprite(x, y, origin1X, origin1Y))
    begin
        idx1 = modelIndex(1, x - origin1X, y - origin1Y);
    end
    if (x >= 640 || y >= 480)
    begin
        color = '0;
    end
    else if (idx1 != '0)
    begin
        color = pal1Model[idx1];
    end
    else if (idx0 != '0)
    begin
        color = pal0Model[idx0];
    end
    else
    begin
        color = bgModel;
    end
    return color;
endfunction

function automatic apbData_t posWord(input int x, input int y);
    return {6'b0, coord_t'(y), 6'b0, coord_t'(x)};
endfunction

// ------------------------------
// stimulus helpers
// ------------------------------
// stops at the falling edge where video shows (x, y)
task automatic waitPixel(input int x, input int y);
    int   cycles;
    logic found;
    cycles = 0;
    found  = 1'b0;
    while (!found && cycles < 2 * frameCycles)
    begin
        @(negedge Clk);
        cycles++;
        found = (int'(video.x) == x) && (int'(video.y) == y);
    end
    if (!found)
    begin
        errorCount++;
        $display("pixel (%0d, %0d) never showed up in the video stream", x, y);
    end
endtask

task automatic loadPalettes();
    apbData_t word;
    for (int i = 0; i < paletteSize; i++)
    begin
        word = $urandom;
        pal0Model[i] = word[23:0];
        word = $urandom;
        pal1Model[i] = word[23:0];
        apbWrite(palette0Base + apbAddr_t'(4 * i), {8'h00, pal0Model[i]}, 1'b0);
        apbWrite(palette1Base + apbAddr_t'(4 * i), {8'h00, pal1Model[i]}, 1'b0);
    end
endtask

task automatic setBackground(input rgb_t color);
    bgModel = color;
    apbWrite(regBackground, {8'h00, color}, 1'b0);
endtask

task automatic placeSprites(input int x0, input int y0, input int x1, input int y1);
    origin0X = x0;
    origin0Y = y0;
    origin1X = x1;
    origin1Y = y1;
    apbWrite(regSprite0Pos, posWord(x0, y0), 1'b0);
    apbWrite(regSprite1Pos, posWord(x1, y1), 1'b0);
endtask

task automatic randomBackground();
    apbData_t word;
    word = $urandom;
    setBackground(word[23:0]);
endtask

// row by row scan of a screen rectangle against the model
task automatic checkBlock(input int x0, input int y0, input int width, input int height);
    int x;
    int y;
    for (int row = 0; row < height; row++)
    begin
        y = y0 + row;
        waitPixel(x0, y);
        for (int col = 0; col < width; col++)
        begin
            x = x0 + col;
            if (col > 0)
            begin
                @(negedge Clk);
            end
            checkCoord("video.x", video.x, coord_t'(x));
            checkRgb($sformatf("video.rgb at (%0d, %0d)", x, y), video.rgb, expectedColor(x, y));
        end
    end
endtask

task automatic checkIdle(input string tag);
    checkBit({tag, " video.active"}, video.active, 1'b0);
    checkBit({tag, " video.hSyncN"}, video.hSyncN, 1'b1);
    checkBit({tag, " video.vSyncN"}, video.vSyncN, 1'b1);
    checkRgb({tag, " video.rgb"}, video.rgb, '0);
endtask

// ------------------------------
// tests
// ------------------------------
task automatic testResetState();
    int errBefore;
    errBefore = errorCount;
    // reset is low from time zero
    for (int c = 0; c < resetCycles - 1; c++)
    begin
        @(negedge Clk);
        checkIdle("in reset");
    end
    @(posedge Clk);
    arstN <= 1'b1;
    // pipeline still holds reset values for two clocks
    repeat (2)
    begin
        @(negedge Clk);
        checkIdle("after reset");
    end
    reportTest("reset state", errBefore);
endtask

task automatic testRegisterAccess();
    int       errBefore;
    apbData_t pos0;
    apbData_t pos1;
    apbData_t bg;
    errBefore = errorCount;
    pos0 = posWord(683, 341);
    pos1 = posWord(17, 402);
    bg   = 32'h00A5_3C96;
    apbWrite(regSprite0Pos, pos0, 1'b0);
    apbWrite(regSprite1Pos, pos1, 1'b0);
    apbWrite(regBackground, bg, 1'b0);
    apbRead(regSprite0Pos, pos0, 1'b0);
    apbRead(regSprite1Pos, pos1, 1'b0);
    apbRead(regBackground, bg, 1'b0);
    // palette entries read as zero
    apbWrite(palette1Base + 8'h0C, 32'h0012_3456, 1'b0);
    apbRead(palette1Base + 8'h0C, '0, 1'b0);
    apbRead(palette0Base, '0, 1'b0);
    // hole in the map, then misaligned
    apbWrite(8'h20, 32'h0000_0001, 1'b1);
    apbRead(8'h20, '0, 1'b1);
    apbWrite(8'h09, 32'h00FF_FFFF, 1'b1);
    apbWrite(8'h01, 32'h0000_0000, 1'b1);
    apbRead(regSprite0Pos, pos0, 1'b0);
    apbRead(regSprite1Pos, pos1, 1'b0);
    apbRead(regBackground, bg, 1'b0);
    reportTest("register access", errBefore);
endtask

task automatic testBackgroundLine();
    int errBefore;
    errBefore = errorCount;
    // x 700 is never in the active area
    placeSprites(700, 0, 700, 0);
    randomBackground();
    waitPixel(0, 200);
    for (int x = 0; x < 800; x++)
    begin
        if (x > 0)
        begin
            @(negedge Clk);
        end
        checkCoord("video.x", video.x, coord_t'(x));
        checkBit("video.active", video.active, x < 640);
        checkRgb($sformatf("video.rgb at x %0d", x), video.rgb, (x < 640) ? bgModel : '0);
    end
    reportTest("background line", errBefore);
endtask

task automatic testSpriteZero();
    int errBefore;
    errBefore = errorCount;
    loadPalettes();
    randomBackground();
    placeSprites(100, 60, 700, 0);
    checkBlock(100, 60, spriteSize, spriteSize);
    reportTest("sprite 0 pixels", errBefore);
endtask

task automatic testSpriteOverlap();
    int errBefore;
    errBefore = errorCount;
    loadPalettes();
    randomBackground();
    // sprite 1 covers the lower right of sprite 0
    placeSprites(200, 100, 204, 103);
    checkBlock(200, 100, 12, 11);
    reportTest("sprite overlap", errBefore);
endtask

task automatic testSyncTiming();
    int errBefore;
    errBefore = errorCount;
    waitPixel(0, 10);
    for (int x = 0; x < 800; x++)
    begin
        if (x > 0)
        begin
            @(negedge Clk);
        end
        checkCoord("video.x", video.x, coord_t'(x));
        checkBit($sformatf("video.hSyncN at x %0d", x), video.hSyncN, !(x >= 656 && x <= 751));
    end
    // next line starts 800 cycles after the previous one
    @(negedge Clk);
    checkCoord("video.x", video.x, '0);
    checkCoord("video.y", video.y, coord_t'(11));
    // vertical sync edge
    waitPixel(799, 489);
    checkBit("video.vSyncN on line 489", video.vSyncN, 1'b1);
    @(negedge Clk);
    checkCoord("video.y", video.y, coord_t'(490));
    checkBit("video.vSyncN on line 490", video.vSyncN, 1'b0);
    waitPixel(0, 492);
    checkBit("video.vSyncN on line 492", video.vSyncN, 1'b1);
    reportTest("sync timing", errBefore);
endtask

//--- verification/tbTop.sv
// run from the project root; pattern model is read from source/spriteData.hex, palettes are random
`default_nettype none

module tbTop;
    import videoPkg::*;

    localparam int clkPeriod    = 20;
    localparam int resetCycles  = 16;
    localparam int testCount    = 6;
    localparam int frameCycles  = int'(hTotal) * int'(vTotal);
    // two frames per test, plus room for the APB traffic
    localparam int watchdogTime = (testCount * 2 * frameCycles + 5000) * clkPeriod;
    localparam int readyLimit   = 16;

    logic      Clk;
    logic      arstN;
    apbReq_t   apbReq;
    apbRsp_t   apbRsp;
    videoOut_t video;

    // reference state for the expected pixels
    patternRow_t patternModel [spriteRows];
    rgb_t        pal0Model [paletteSize];
    rgb_t        pal1Model [paletteSize];
    rgb_t        bgModel;
    int          origin0X;
    int          origin0Y;
    int          origin1X;
    int          origin1Y;

    int          errorCount;
    int          checkCount;
    int          testsRun;

    videoTop i_dut (
        .Clk    (Clk),
        .arstN  (arstN),
        .apbReq (apbReq),
        .apbRsp (apbRsp),
        .video  (video)
    );

    // ------------------------------
    // clock and watchdog
    // ------------------------------
    initial
    begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    initial
    begin
        #(watchdogTime);
        $display("timeout: tests still running after %0d time units", watchdogTime);
        $display("Checks failed");
        $finish;
    end

    // ------------------------------
    // compare tasks
    // ------------------------------
    task automatic checkRgb(input string name, input rgb_t actual, input rgb_t expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("MISMATCH at %0t: %s is %06h, expected %06h", $time, name, actual, expected);
        end
    endtask

    task automatic checkData(input string name, input apbData_t actual, input apbData_t expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("MISMATCH at %0t: %s is %08h, expected %08h", $time, name, actual, expected);
        end
    endtask

    task automatic checkCoord(input string name, input coord_t actual, input coord_t expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected)
        begin
            errorCount++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // ------------------------------
    // APB driver
    // ------------------------------
    // setup cycle, then access cycle until pready
    task automatic apbTransfer(input logic write, input apbAddr_t addr, input apbData_t wdata,
                               output apbData_t rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge Clk);
        apbReq.psel    <= 1'b1;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= write;
        apbReq.paddr   <= addr;
        apbReq.pwdata  <= wdata;
        @(posedge Clk);
        apbReq.penable <= 1'b1;
        @(negedge Clk);
        while (!apbRsp.pready && waits < readyLimit)
        begin
            @(negedge Clk);
            waits++;
        end
        if (!apbRsp.pready)
        begin
            errorCount++;
            $display("APB transfer to address %02h got no pready", addr);
        end
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        // write lands on this edge
        @(posedge Clk);
        apbReq.psel    <= 1'b0;
        apbReq.penable <= 1'b0;
        apbReq.pwrite  <= 1'b0;
    endtask

    task automatic apbWrite(input apbAddr_t addr, input apbData_t wdata, input logic expectErr);
        apbData_t rdata;
        logic     err;
        apbTransfer(1'b1, addr, wdata, rdata, err);
        checkBit($sformatf("pslverr on write to %02h", addr), err, expectErr);
    endtask

    task automatic apbRead(input apbAddr_t addr, input apbData_t expected, input logic expectErr);
        apbData_t rdata;
        logic     err;
        apbTransfer(1'b0, addr, '0, rdata, err);
        checkBit($sformatf("pslverr on read of %02h", addr), err, expectErr);
        if (!expectErr)
        begin
            checkData($sformatf("prdata from %02h", addr), rdata, expected);
        end
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testsRun++;
        if (errorCount == errBefore)
        begin
            $display("test %0d %s: ok", testsRun, name);
        end
        else
        begin
            $display("test %0d %s: FAILED with %0d errors", testsRun, name, errorCount - errBefore);
        end
    endtask

    `include "tbTests.svh"

    // ------------------------------
    // test sequence
    // ------------------------------
    initial
    begin
        arstN      <= 1'b0;
        apbReq     <= '0;
        errorCount = 0;
        checkCount = 0;
        testsRun   = 0;
        void'($urandom(70));
        $readmemh("source/spriteData.hex", patternModel);
        testResetState();
        testRegisterAccess();
        testBackgroundLine();
        testSpriteZero();
        testSpriteOverlap();
        testSyncTiming();
        $display("summary: %0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/spriteData.hex
// one 32-bit pattern row per line, 8 nibbles, column 0 in the top nibble
// lines 0-7 are sprite 0 rows 0-7, lines 8-15 are sprite 1 rows 0-7
00122100
01233210
12344321
23455432
23455432
12344321
01233210
00122100
F000000F
0E0000E0
00D00D00
000CC000
000BB000
00A00A00
09000090
80000008

//--- sim.f
+incdir+verification
source/videoPkg.sv
source/vgaTimer.sv
source/apbRegs.sv
source/spriteFetch.sv
source/colorMapper.sv
source/videoTop.sv
verification/tbTop.sv

//--- run.sh
#!/bin/sh
# builds tbTop with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

# the sprite units read their pattern file from the working directory
ln -sf source/spriteData.hex spriteData.hex

verilator --binary --timing --assert -j 0 --top-module tbTop -f sim.f -o simTop
./obj_dir/simTop > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation finished without failures"
